// File: design/fetch_pkg.sv
package fetch_pkg;

    //////////////////////////////////////////////////
    // address geometry
    //////////////////////////////////////////////////
    localparam int VADDR_W       = 32;
    localparam int LINE_BYTES    = 16;
    localparam int LINE_OFS_BITS = $clog2(LINE_BYTES);   // 4
    localparam int FIP_W         = VADDR_W - LINE_OFS_BITS;
    localparam int PAGE_BITS     = 12;
    localparam int VPAGE_W       = VADDR_W - PAGE_BITS;
    localparam int PFRAME_W      = 20;
    localparam int FRAME_LO_BITS = 3;                    // frame bits kept in paddr
    localparam int PADDR_W       = FRAME_LO_BITS + PAGE_BITS;
    localparam int LINE_W        = LINE_BYTES * 8;

    // default sizes, overridden from the top
    localparam int TLB_ENTRIES = 8;
    localparam int CACHE_LINES = 16;   // per bank

    // control-flow select bit positions
    localparam int CF_BRANCH  = 0;
    localparam int CF_RESTEER = 1;
    localparam int CF_INIT    = 2;

    //////////////////////////////////////////////////
    // vector types
    //////////////////////////////////////////////////
    typedef logic [FIP_W-1:0]    fip_t;     // line address, vaddr[31:4]
    typedef logic [VADDR_W-1:0]  vaddr_t;
    typedef logic [VPAGE_W-1:0]  vpage_t;
    typedef logic [PFRAME_W-1:0] pframe_t;
    typedef logic [PADDR_W-1:0]  paddr_t;   // {frame[2:0], page offset}
    typedef logic [LINE_W-1:0]   line_t;
    typedef logic [2:0]          cf_sel_t;  // {init, resteer, branch}

endpackage

// File: design/xlate_if.sv
`timescale 1ns/1ps

// one bank's fetch address going into the TLB and the translation coming out
interface xlate_if import fetch_pkg::*; ();

    fip_t   fip;        // bank line address
    paddr_t paddr;      // physical byte address for the cache
    logic   hit;        // valid, present entry matched
    logic   miss;
    logic   prot_exc;   // fetch from a PCD page

    modport tlb (
        input  fip,
        output paddr,
        output hit,
        output miss,
        output prot_exc
    );

    modport bank (
        input fip,
        input paddr,
        input hit,
        input miss,
        input prot_exc
    );

endinterface

// File: design/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl import fetch_pkg::*; (
    input  logic    init_i,
    input  logic    resteer_i,
    input  logic    branch_i,
    input  vaddr_t  init_addr_i,
    output cf_sel_t cf_sel_o,
    output logic    is_cf_o,
    output fip_t    init_fip_even_o,
    output fip_t    init_fip_odd_o
);

    fip_t init_line;
    fip_t next_line;

    //////////////////////////////////////////////////
    // control-flow priority
    //////////////////////////////////////////////////

    // init beats resteer beats branch
    assign cf_sel_o[CF_INIT]    = init_i;
    assign cf_sel_o[CF_RESTEER] = ~init_i & resteer_i;
    assign cf_sel_o[CF_BRANCH]  = ~init_i & ~resteer_i & branch_i;

    assign is_cf_o = init_i | resteer_i | branch_i;

    //////////////////////////////////////////////////
    // init address split
    //////////////////////////////////////////////////
    assign init_line = init_addr_i[VADDR_W-1:LINE_OFS_BITS];
    assign next_line = init_line + fip_t'(1);   // following 16-byte line

    // bit 4 tells which bank owns the init line, the other one
    // starts on the line after it
    always_comb begin
        if (init_addr_i[LINE_OFS_BITS]) begin
            init_fip_odd_o  = init_line;
            init_fip_even_o = next_line;
        end else begin
            init_fip_even_o = init_line;
            init_fip_odd_o  = next_line;
        end
    end

    // both fip_select muxes are and-or, two hot bits would merge addresses
    always_comb begin
        assert ($onehot0(cf_sel_o) && (is_cf_o == (|cf_sel_o)))
            else $error("fetch_ctrl: control-flow select not one-hot");
    end

endmodule

// File: design/fip_select.sv
`timescale 1ns/1ps

module fip_select import fetch_pkg::*; #(
    parameter bit PARITY = 1'b0     // 0 even bank, 1 odd bank
) (
    input  logic    clk,
    input  logic    reset_i,
    input  cf_sel_t cf_sel_i,
    input  logic    is_cf_i,
    input  fip_t    init_fip_i,
    input  fip_t    bp_fip_i,
    input  fip_t    wb_fip_i,
    input  logic    latch_loaded_i,
    output fip_t    fip_o
);

    fip_t fip_q;     // sequential fetch address
    fip_t cf_fip;    // selected control-flow address
    logic load;

    // and-or mux, select is one-hot from fetch_ctrl
    assign cf_fip = ({FIP_W{cf_sel_i[CF_INIT]}}    & init_fip_i)
                  | ({FIP_W{cf_sel_i[CF_RESTEER]}} & wb_fip_i)
                  | ({FIP_W{cf_sel_i[CF_BRANCH]}}  & bp_fip_i);

    // control flow goes out in the same cycle
    assign fip_o = is_cf_i ? cf_fip : fip_q;

    // step when the line latch took our line, or on any redirect
    assign load = latch_loaded_i | is_cf_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fip_q <= fip_t'(PARITY);       // bank 0 starts at line 0, bank 1 at line 1
        end else if (load) begin
            fip_q <= fip_o + fip_t'(2);    // skip the other bank's line
        end
    end

    // the redirect addresses come from outside, they must keep the bank parity
    a_fip_parity: assert property (
        @(posedge clk) disable iff (reset_i) fip_q[0] == PARITY
    ) else $error("fip_select: bank %0d register lost its parity", PARITY);

endmodule

// File: design/itlb.sv
`timescale 1ns/1ps

module itlb import fetch_pkg::*; #(
    parameter int N_ENTRIES = TLB_ENTRIES
) (
    input  vpage_t  [N_ENTRIES-1:0] vp_i,
    input  pframe_t [N_ENTRIES-1:0] pf_i,
    input  logic    [N_ENTRIES-1:0] entry_v_i,
    input  logic    [N_ENTRIES-1:0] entry_p_i,
    input  logic    [N_ENTRIES-1:0] entry_pcd_i,
    xlate_if.tlb                    xl
);

    localparam int IDX_W = (N_ENTRIES > 1) ? $clog2(N_ENTRIES) : 1;

    vaddr_t               vaddr;
    logic [N_ENTRIES-1:0] match;
    logic [IDX_W-1:0]     win;      // lowest matching entry
    logic                 any_hit;

    // the bank fetches whole lines, low nibble is zero
    assign vaddr = {xl.fip, {LINE_OFS_BITS{1'b0}}};

    //////////////////////////////////////////////////
    // compare all entries
    //////////////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < N_ENTRIES; i++) begin
            match[i] = entry_v_i[i] & entry_p_i[i]
                     & (vp_i[i] == vaddr[VADDR_W-1:PAGE_BITS]);
        end
    end

    // walk down so the lowest index is the last one written
    always_comb begin
        win = '0;
        for (int i = N_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                win = IDX_W'(i);
            end
        end
    end

    assign any_hit = |match;

    //////////////////////////////////////////////////
    // translation result
    //////////////////////////////////////////////////
    assign xl.hit  = any_hit;
    assign xl.miss = ~any_hit;

    // uncached I/O page, no instruction fetch from it
    assign xl.prot_exc = any_hit & entry_pcd_i[win];

    // only three frame bits reach the cache
    assign xl.paddr = {pf_i[win][FRAME_LO_BITS-1:0], vaddr[PAGE_BITS-1:0]};

endmodule

// File: design/icache_bank.sv
`timescale 1ns/1ps

module icache_bank import fetch_pkg::*; #(
    parameter bit PARITY  = 1'b0,
    parameter int N_LINES = CACHE_LINES
) (
    input  logic  clk,
    input  logic  reset_i,
    xlate_if.bank xl,
    input  logic  refill_valid_i,
    input  line_t refill_line_i,
    output line_t line_o,
    output logic  cache_miss_o
);

    // bit 4 is fixed per bank, the index starts above it
    localparam int IDX_W  = $clog2(N_LINES);
    localparam int IDX_LO = LINE_OFS_BITS + 1;
    localparam int TAG_LO = IDX_LO + IDX_W;
    localparam int TAG_W  = PADDR_W - TAG_LO;

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [TAG_W-1:0] tag_t;

    line_t              data_q [N_LINES];
    tag_t               tag_q  [N_LINES];
    logic [N_LINES-1:0] valid_q;

    idx_t idx;
    tag_t tag;
    logic lookup;      // translation usable for a fetch
    logic tag_hit;
    logic refill_we;

    //////////////////////////////////////////////////
    // lookup
    //////////////////////////////////////////////////
    assign idx = xl.paddr[TAG_LO-1:IDX_LO];      // paddr[8:5]
    assign tag = xl.paddr[PADDR_W-1:TAG_LO];     // paddr[14:9]

    assign lookup  = xl.hit & ~xl.prot_exc;
    assign tag_hit = valid_q[idx] & (tag_q[idx] == tag);

    // TLB miss and exception are reported by the TLB, not as cache misses
    assign cache_miss_o = lookup & ~tag_hit;
    assign line_o       = data_q[idx];

    //////////////////////////////////////////////////
    // refill
    //////////////////////////////////////////////////
    assign refill_we = refill_valid_i & lookup;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (refill_we) begin
            valid_q[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (refill_we) begin
            data_q[idx] <= refill_line_i;   // readable next cycle
            tag_q[idx]  <= tag;
        end
    end

    // refill pulse targets the line that is missing right now
    a_refill_on_miss: assert property (
        @(posedge clk) disable iff (reset_i) refill_valid_i |-> cache_miss_o
    ) else $error("icache_bank %0d: refill without a miss", PARITY);

    // a translated fetch must land in this bank's half of the lines
    a_bank_parity: assert property (
        @(posedge clk) disable iff (reset_i) xl.hit |-> (xl.paddr[LINE_OFS_BITS] == PARITY)
    ) else $error("icache_bank %0d: address of the other bank", PARITY);

endmodule

// File: design/fetch_top.sv
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
    parameter int TLB_ENTRIES = fetch_pkg::TLB_ENTRIES,
    parameter int CACHE_LINES = fetch_pkg::CACHE_LINES
) (
    input  logic                      clk,
    input  logic                      reset_i,

    // control flow
    input  logic                      init_i,
    input  vaddr_t                    init_addr_i,
    input  logic                      resteer_i,
    input  fip_t                      wb_fip_even_i,
    input  fip_t                      wb_fip_odd_i,
    input  logic                      branch_i,
    input  fip_t                      bp_fip_even_i,
    input  fip_t                      bp_fip_odd_i,
    input  logic                      even_latch_loaded_i,
    input  logic                      odd_latch_loaded_i,

    // TLB contents
    input  vpage_t  [TLB_ENTRIES-1:0] vp_i,
    input  pframe_t [TLB_ENTRIES-1:0] pf_i,
    input  logic    [TLB_ENTRIES-1:0] tlb_entry_v_i,
    input  logic    [TLB_ENTRIES-1:0] tlb_entry_p_i,
    input  logic    [TLB_ENTRIES-1:0] tlb_entry_pcd_i,

    // line refill
    input  logic                      refill_valid_i,
    input  logic                      refill_odd_i,
    input  line_t                     refill_line_i,

    output fip_t                      fip_even_o,
    output fip_t                      fip_odd_o,
    output line_t                     line_even_o,
    output line_t                     line_odd_o,
    output logic                      cache_miss_even_o,
    output logic                      cache_miss_odd_o,
    output logic                      tlb_miss_even_o,
    output logic                      tlb_miss_odd_o,
    output logic                      prot_exc_even_o,
    output logic                      prot_exc_odd_o
);

    cf_sel_t cf_sel;
    logic    is_cf;
    fip_t    init_fip_even;
    fip_t    init_fip_odd;
    logic    refill_even;
    logic    refill_odd;

    xlate_if xl_even ();
    xlate_if xl_odd ();

    //////////////////////////////////////////////////
    // fetch address generation
    //////////////////////////////////////////////////
    fetch_ctrl i_ctrl (
        .init_i          (init_i),
        .resteer_i       (resteer_i),
        .branch_i        (branch_i),
        .init_addr_i     (init_addr_i),
        .cf_sel_o        (cf_sel),
        .is_cf_o         (is_cf),
        .init_fip_even_o (init_fip_even),
        .init_fip_odd_o  (init_fip_odd)
    );

    fip_select #(.PARITY(1'b0)) i_fip_even (
        .clk            (clk),
        .reset_i        (reset_i),
        .cf_sel_i       (cf_sel),
        .is_cf_i        (is_cf),
        .init_fip_i     (init_fip_even),
        .bp_fip_i       (bp_fip_even_i),
        .wb_fip_i       (wb_fip_even_i),
        .latch_loaded_i (even_latch_loaded_i),
        .fip_o          (xl_even.fip)
    );

    fip_select #(.PARITY(1'b1)) i_fip_odd (
        .clk            (clk),
        .reset_i        (reset_i),
        .cf_sel_i       (cf_sel),
        .is_cf_i        (is_cf),
        .init_fip_i     (init_fip_odd),
        .bp_fip_i       (bp_fip_odd_i),
        .wb_fip_i       (wb_fip_odd_i),
        .latch_loaded_i (odd_latch_loaded_i),
        .fip_o          (xl_odd.fip)
    );

    //////////////////////////////////////////////////
    // translation, both TLBs see the same entries
    //////////////////////////////////////////////////
    itlb #(.N_ENTRIES(TLB_ENTRIES)) i_itlb_even (
        .vp_i        (vp_i),
        .pf_i        (pf_i),
        .entry_v_i   (tlb_entry_v_i),
        .entry_p_i   (tlb_entry_p_i),
        .entry_pcd_i (tlb_entry_pcd_i),
        .xl          (xl_even.tlb)
    );

    itlb #(.N_ENTRIES(TLB_ENTRIES)) i_itlb_odd (
        .vp_i        (vp_i),
        .pf_i        (pf_i),
        .entry_v_i   (tlb_entry_v_i),
        .entry_p_i   (tlb_entry_p_i),
        .entry_pcd_i (tlb_entry_pcd_i),
        .xl          (xl_odd.tlb)
    );

    //////////////////////////////////////////////////
    // cache banks
    //////////////////////////////////////////////////
    assign refill_even = refill_valid_i & ~refill_odd_i;
    assign refill_odd  = refill_valid_i & refill_odd_i;

    icache_bank #(.PARITY(1'b0), .N_LINES(CACHE_LINES)) i_bank_even (
        .clk            (clk),
        .reset_i        (reset_i),
        .xl             (xl_even.bank),
        .refill_valid_i (refill_even),
        .refill_line_i  (refill_line_i),
        .line_o         (line_even_o),
        .cache_miss_o   (cache_miss_even_o)
    );

    icache_bank #(.PARITY(1'b1), .N_LINES(CACHE_LINES)) i_bank_odd (
        .clk            (clk),
        .reset_i        (reset_i),
        .xl             (xl_odd.bank),
        .refill_valid_i (refill_odd),
        .refill_line_i  (refill_line_i),
        .line_o         (line_odd_o),
        .cache_miss_o   (cache_miss_odd_o)
    );

    assign fip_even_o      = xl_even.fip;
    assign fip_odd_o       = xl_odd.fip;
    assign tlb_miss_even_o = xl_even.miss;
    assign tlb_miss_odd_o  = xl_odd.miss;
    assign prot_exc_even_o = xl_even.prot_exc;
    assign prot_exc_odd_o  = xl_odd.prot_exc;

endmodule

// File: tb/tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch import fetch_pkg::*; ();

    localparam int N_TLB    = 8;
    localparam int N_LINES  = 16;
    localparam int MAX_WAIT = 20;   // cycles

    typedef struct {
        string  name;
        logic   init;
        vaddr_t init_addr;
        logic   resteer;
        logic   branch;
        fip_t   wb_even;
        fip_t   wb_odd;
        fip_t   bp_even;
        fip_t   bp_odd;
        logic   ll_even;
        logic   ll_odd;
        logic   refill;
        logic   refill_odd;
    } row_t;

    logic    clk = 1'b0;
    logic    reset_i;
    logic    init_i;
    logic    resteer_i;
    logic    branch_i;
    vaddr_t  init_addr_i;
    fip_t    wb_fip_even_i;
    fip_t    wb_fip_odd_i;
    fip_t    bp_fip_even_i;
    fip_t    bp_fip_odd_i;
    logic    even_latch_loaded_i;
    logic    odd_latch_loaded_i;
    vpage_t  [N_TLB-1:0] vp_i;
    pframe_t [N_TLB-1:0] pf_i;
    logic    [N_TLB-1:0] tlb_entry_v_i;
    logic    [N_TLB-1:0] tlb_entry_p_i;
    logic    [N_TLB-1:0] tlb_entry_pcd_i;
    logic    refill_valid_i;
    logic    refill_odd_i;
    line_t   refill_line_i;
    fip_t    fip_even_o;
    fip_t    fip_odd_o;
    line_t   line_even_o;
    line_t   line_odd_o;
    logic    cache_miss_even_o;
    logic    cache_miss_odd_o;
    logic    tlb_miss_even_o;
    logic    tlb_miss_odd_o;
    logic    prot_exc_even_o;
    logic    prot_exc_odd_o;

    // reference model state per bank (0 even, 1 odd)
    fip_t               m_fip [2];
    line_t              m_data [2][N_LINES];
    logic [5:0]         m_tag [2][N_LINES];
    logic [N_LINES-1:0] m_valid [2];
    logic [31:0]        rng_state = 32'h8365f458;
    row_t               rows [$];

    fetch_top #(.TLB_ENTRIES(N_TLB), .CACHE_LINES(N_LINES)) i_dut (.*);

    always #50 clk = ~clk;

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic line_t random_line();
        line_t l;
        for (int i = 0; i < 4; i++) begin
            rng_state = xorshift32(rng_state);
            l[i*32 +: 32] = rng_state;
        end
        return l;
    endfunction

    task automatic add_row(input string name, input logic ini, input vaddr_t ia,
                           input logic rst, input logic brn, input fip_t wbe, input fip_t wbo,
                           input fip_t bpe, input fip_t bpo, input logic lle, input logic llo,
                           input logic rf, input logic rfo);
        row_t r;
        r.name = name;
        r.init = ini;
        r.init_addr = ia;
        r.resteer = rst;
        r.branch = brn;
        r.wb_even = wbe;
        r.wb_odd = wbo;
        r.bp_even = bpe;
        r.bp_odd = bpo;
        r.ll_even = lle;
        r.ll_odd = llo;
        r.refill = rf;
        r.refill_odd = rfo;
        rows.push_back(r);
    endtask

    task automatic check_fip(input string name, input fip_t exp, input fip_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_line(input string name, input line_t exp, input line_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////
    function automatic fip_t expect_fip(input row_t r, input int b);
        fip_t init_line;
        init_line = r.init_addr[31:4];
        if (r.init) begin
            // bank whose parity equals bit 4 gets the init line
            return (r.init_addr[4] == b[0]) ? init_line : init_line + fip_t'(1);
        end else if (r.resteer) begin
            return (b != 0) ? r.wb_odd : r.wb_even;
        end else if (r.branch) begin
            return (b != 0) ? r.bp_odd : r.bp_even;
        end
        return m_fip[b];
    endfunction

    task automatic bank_model(input int b, input fip_t f, output logic t_miss,
                              output logic prot, output logic c_miss, output logic hit_line,
                              output int idx, output logic [5:0] tag);
        logic   found;
        int     win;
        paddr_t pa;
        found = 1'b0;
        win = 0;
        for (int i = 0; i < N_TLB; i++) begin
            if (!found && tlb_entry_v_i[i] && tlb_entry_p_i[i] && vp_i[i] == f[27:8]) begin
                found = 1'b1;   // lowest index wins
                win = i;
            end
        end
        pa = {pf_i[win][2:0], f[7:0], 4'h0};
        idx = int'(pa[8:5]);
        tag = pa[14:9];
        t_miss = !found;
        prot = found && tlb_entry_pcd_i[win];
        hit_line = found && !prot && m_valid[b][idx] && (m_tag[b][idx] == tag);
        c_miss = found && !prot && !hit_line;
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (fip_even_o !== fip_t'(0) || fip_odd_o !== fip_t'(1)) begin
            @(negedge clk);
            cycles++;
            if (cycles > MAX_WAIT) begin
                $display("fetch addresses did not reach their reset values in time");
                $display("SIMULATION FAILED");
                $fatal(1);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    initial begin
        row_t       r;
        fip_t       exp_fip;
        fip_t       act_fip;
        logic       t_miss;
        logic       prot;
        logic       c_miss;
        logic       hit_line;
        logic       ll;
        int         idx;
        logic [5:0] tag;
        string      bank;

        reset_i = 1'b1;
        {init_i, resteer_i, branch_i} = 3'b000;
        init_addr_i = '0;
        {wb_fip_even_i, wb_fip_odd_i, bp_fip_even_i, bp_fip_odd_i} = '0;
        {even_latch_loaded_i, odd_latch_loaded_i} = 2'b00;
        {refill_valid_i, refill_odd_i} = 2'b00;
        refill_line_i = '0;

        // page 0 cached, page 1 I/O, page 2 has no entry both valid and present
        // page 3 shares the frame of page 0, entry 5 is an I/O copy hidden behind entry 0
        vp_i = '0;
        pf_i = '0;
        tlb_entry_v_i = 8'b0011_0111;
        tlb_entry_p_i = 8'b0011_1011;
        tlb_entry_pcd_i = 8'b0010_0010;
        vp_i[1] = 20'h00001;
        vp_i[2] = 20'h00002;
        vp_i[3] = 20'h00002;
        vp_i[4] = 20'h00003;
        pf_i[0] = 20'h00003;
        pf_i[1] = 20'h00002;
        pf_i[2] = 20'h00004;
        pf_i[4] = 20'h00003;
        pf_i[5] = 20'h00007;

        m_fip[0] = fip_t'(0);
        m_fip[1] = fip_t'(1);
        m_valid[0] = '0;
        m_valid[1] = '0;

        //       name            init addr      rs br wb_e    wb_o    bp_e    bp_o  ll_e/o rf/odd
        add_row("reset_value",   0, 32'h0,     0, 0, 28'h0,  28'h0,  28'h0,  28'h0,  0, 0, 0, 0);
        add_row("refill_even",   0, 32'h0,     0, 0, 28'h0,  28'h0,  28'h0,  28'h0,  0, 0, 1, 0);
        add_row("hit_even",      0, 32'h0,     0, 0, 28'h0,  28'h0,  28'h0,  28'h0,  1, 1, 0, 0);
        add_row("step",          0, 32'h0,     0, 0, 28'h0,  28'h0,  28'h0,  28'h0,  1, 1, 0, 0);
        add_row("hold_even",     0, 32'h0,     0, 0, 28'h0,  28'h0,  28'h0,  28'h0,  0, 1, 0, 0);
        add_row("hold_odd",      0, 32'h0,     0, 0, 28'h0,  28'h0,  28'h0,  28'h0,  1, 0, 0, 0);
        add_row("init_bit4_clr", 1, 32'h40,    0, 0, 28'h0,  28'h0,  28'h0,  28'h0,  0, 0, 0, 0);
        add_row("after_init",    0, 32'h0,     0, 0, 28'h0,  28'h0,  28'h0,  28'h0,  1, 1, 0, 0);
        add_row("init_bit4_set", 1, 32'h70,    0, 0, 28'h0,  28'h0,  28'h0,  28'h0,  0, 0, 0, 0);
        add_row("after_init2",   0, 32'h0,     0, 0, 28'h0,  28'h0,  28'h0,  28'h0,  1, 1, 0, 0);
        add_row("prio_all",      1, 32'h0,     1, 1, 28'h20, 28'h21, 28'h40, 28'h41, 0, 0, 0, 0);
        add_row("prio_resteer",  0, 32'h0,     1, 1, 28'h20, 28'h21, 28'h40, 28'h41, 0, 0, 0, 0);
        add_row("prio_branch",   0, 32'h0,     0, 1, 28'h20, 28'h21, 28'h40, 28'h41, 0, 0, 0, 0);
        add_row("tlb_miss",      0, 32'h0,     0, 1, 28'h0,  28'h0,  28'h200, 28'h201, 0, 0, 0, 0);
        add_row("prot_exc",      0, 32'h0,     0, 1, 28'h0,  28'h0,  28'h100, 28'h101, 0, 0, 0, 0);
        add_row("tag_conflict",  0, 32'h0,     0, 1, 28'h0,  28'h0,  28'h20, 28'h21, 0, 0, 0, 0);
        add_row("refill_odd",    0, 32'h0,     1, 0, 28'h20, 28'h21, 28'h0,  28'h0,  0, 0, 1, 1);
        add_row("back_to_0",     0, 32'h0,     0, 1, 28'h0,  28'h0,  28'h0,  28'h1,  0, 0, 0, 0);
        add_row("hit_odd",       0, 32'h0,     0, 1, 28'h0,  28'h0,  28'h20, 28'h21, 0, 0, 0, 0);
        add_row("alias_page3",   0, 32'h0,     0, 1, 28'h0,  28'h0,  28'h300, 28'h301, 0, 0, 0, 0);

        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
        end
        @(negedge clk);
        reset_i = 1'b0;
        wait_reset_release();

        foreach (rows[n]) begin
            r = rows[n];
            @(negedge clk);
            init_i = r.init;
            init_addr_i = r.init_addr;
            resteer_i = r.resteer;
            branch_i = r.branch;
            wb_fip_even_i = r.wb_even;
            wb_fip_odd_i = r.wb_odd;
            bp_fip_even_i = r.bp_even;
            bp_fip_odd_i = r.bp_odd;
            even_latch_loaded_i = r.ll_even;
            odd_latch_loaded_i = r.ll_odd;
            refill_valid_i = r.refill;
            refill_odd_i = r.refill_odd;
            if (r.refill) begin
                refill_line_i = random_line();
            end
            #10;   // combinational outputs settled
            for (int b = 0; b < 2; b++) begin
                bank = (b != 0) ? "odd" : "even";
                exp_fip = expect_fip(r, b);
                bank_model(b, exp_fip, t_miss, prot, c_miss, hit_line, idx, tag);
                act_fip = (b != 0) ? fip_odd_o : fip_even_o;
                check_fip($sformatf("%s fip_%s", r.name, bank), exp_fip, act_fip);
                check_flag($sformatf("%s tlb_miss_%s", r.name, bank), t_miss,
                           (b != 0) ? tlb_miss_odd_o : tlb_miss_even_o);
                check_flag($sformatf("%s prot_exc_%s", r.name, bank), prot,
                           (b != 0) ? prot_exc_odd_o : prot_exc_even_o);
                check_flag($sformatf("%s cache_miss_%s", r.name, bank), c_miss,
                           (b != 0) ? cache_miss_odd_o : cache_miss_even_o);
                if (hit_line) begin
                    check_line($sformatf("%s line_%s", r.name, bank), m_data[b][idx],
                               (b != 0) ? line_odd_o : line_even_o);
                end
                // model state after the coming rising edge
                if (r.refill && r.refill_odd == b[0] && !t_miss && !prot) begin
                    m_data[b][idx] = refill_line_i;
                    m_tag[b][idx] = tag;
                    m_valid[b][idx] = 1'b1;
                end
                ll = (b != 0) ? r.ll_odd : r.ll_even;
                if (ll || r.init || r.resteer || r.branch) begin
                    m_fip[b] = exp_fip + fip_t'(2);
                end
            end
        end

        @(negedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: filelist.f
design/fetch_pkg.sv
design/xlate_if.sv
design/fetch_ctrl.sv
design/fip_select.sv
design/itlb.sv
design/icache_bank.sv
design/fetch_top.sv
tb/tb_fetch.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED" || { echo "run failed"; exit 1; }

clean:
	rm -rf $(OBJ_DIR)
